// File: sources.f
verilog/wb_bus_pkg.sv
verilog/wb_map_pkg.sv
verilog/wb_rr_arbiter.sv
verilog/wb_sram_target.sv
verilog/wb_xbar_2x2.sv
verilog/wb_soc_top.sv
testbench/wb_xbar_chk.sv
testbench/tb_monitor.sv
testbench/tb_top.sv

// File: testbench/tb_monitor.sv
/*
 * Transfer monitor for both master ports
 * Byte-wide reference memory per window, response and data checks
 */
`timescale 1ns/1ps

module tb_monitor (
	input  logic                                 clk,
	input  logic                                 rstn,
	input  logic [1:0]                           cyc_i,
	input  logic [1:0]                           stb_i,
	input  logic [1:0]                           we_i,
	input  logic [1:0][wb_bus_pkg::ADDR_W-1:0]   adr_i,
	input  logic [1:0][wb_bus_pkg::SEL_W-1:0]    sel_i,
	input  logic [1:0][wb_bus_pkg::DATA_W-1:0]   dat_w_i,
	input  logic [1:0][wb_bus_pkg::DATA_W-1:0]   dat_r_i,
	input  logic [1:0]                           ack_i,
	input  logic [1:0]                           err_i,
	output int                                   err_cnt_o,
	output int                                   chk_cnt_o
);

	import wb_bus_pkg::*;
	import wb_map_pkg::*;

	localparam int WIN_BYTES = 1024;

	// Model bytes and written flags, one row per window
	logic [7:0] mdl     [2][WIN_BYTES];
	bit         written [2][WIN_BYTES];

	// Outstanding request of each master
	bit                pend  [2];
	logic              p_we  [2];
	logic [ADDR_W-1:0] p_adr [2];
	logic [SEL_W-1:0]  p_sel [2];
	logic [DATA_W-1:0] p_dat [2];

	initial begin
		err_cnt_o = 0;
		chk_cnt_o = 0;
	end

	// Window number, or -1 when unmapped
	function automatic int window_of(input logic [ADDR_W-1:0] a);
		if (a >= S0_BASE_DEF && a <= S0_LIMIT_DEF) begin
			return 0;
		end
		if (a >= S1_BASE_DEF && a <= S1_LIMIT_DEF) begin
			return 1;
		end
		return -1;
	endfunction

	task automatic report_value(input string sig, input logic [DATA_W-1:0] exp_v,
			input logic [DATA_W-1:0] got_v);
		err_cnt_o++;
		$display("Fail %0t %s expected %h got %h", $time, sig, exp_v, got_v);
	endtask

	// Response arrived, check it and apply writes in ack order
	task automatic finish_transfer(input int m);
		int         w;
		int         off;
		logic [7:0] got;
		w = window_of(p_adr[m]);
		chk_cnt_o++;
		if (w < 0) begin
			// Unmapped: err with zero data, model untouched
			if (!err_i[m]) begin
				report_value($sformatf("m%0d_err_o", m), 1, err_i[m]);
			end
			if (dat_r_i[m] !== '0) begin
				report_value($sformatf("m%0d_dat_r_o", m), '0, dat_r_i[m]);
			end
		end else if (!ack_i[m]) begin
			report_value($sformatf("m%0d_ack_o", m), 1, ack_i[m]);
		end else begin
			off = int'(p_adr[m] - ((w == 0) ? S0_BASE_DEF : S1_BASE_DEF));
			for (int b = 0; b < SEL_W; b++) begin
				got = dat_r_i[m][b*8 +: 8];
				if (p_we[m]) begin
					if (p_sel[m][b]) begin
						mdl[w][off+b]     = p_dat[m][b*8 +: 8];
						written[w][off+b] = 1'b1;
					end
				end else if (written[w][off+b] && got !== mdl[w][off+b]) begin
					// Unwritten bytes are never compared
					report_value($sformatf("m%0d_dat_r_o byte %0d", m, b),
						DATA_W'(mdl[w][off+b]), DATA_W'(got));
				end
			end
		end
	endtask

	always @(posedge clk) begin
		for (int m = 0; m < 2; m++) begin
			if (!rstn) begin
				pend[m] = 1'b0;
			end else if (ack_i[m] || err_i[m]) begin
				if (!pend[m]) begin
					err_cnt_o++;
					$display("Error at %0t: master %0d got a response with no request open",
						$time, m);
				end else begin
					finish_transfer(m);
					pend[m] = 1'b0;
				end
			end else if (cyc_i[m] && stb_i[m] && !pend[m]) begin
				// New request seen on its first cycle
				pend[m]  = 1'b1;
				p_we[m]  = we_i[m];
				p_adr[m] = adr_i[m];
				p_sel[m] = sel_i[m];
				p_dat[m] = dat_w_i[m];
			end
		end
	end

endmodule

// File: testbench/tb_top.sv
/*
 * Testbench top: clock, reset, seeded random traffic from two masters
 * DUT instance, transfer monitor and cycle-limit timeout
 */
`timescale 1ns/1ps

module tb_top;

	import wb_bus_pkg::*;
	import wb_map_pkg::*;

	localparam int N_TRANS = 200;
	localparam int SEED    = 83388;
	// Both masters, up to 3 idle plus 6 bus cycles per transfer, plus margin
	localparam int MAX_CYCLES = 2 * N_TRANS * (3 + 6) + 100;

	logic                   clk;
	logic                   rstn;
	// Index 0 is master 0, index 1 is master 1
	logic [1:0]             cyc;
	logic [1:0]             stb;
	logic [1:0]             we;
	logic [1:0][ADDR_W-1:0] adr;
	logic [1:0][SEL_W-1:0]  sel;
	logic [1:0][DATA_W-1:0] dat_w;
	wire  [1:0][DATA_W-1:0] dat_r;
	wire  [1:0]             ack;
	wire  [1:0]             err;

	int cycle_cnt = 0;
	int err_cnt;
	int chk_cnt;
	int total_errs;

	always #50 clk = ~clk;

	// 45% window 0, 45% window 1, 10% in the unmapped gap
	function automatic logic [ADDR_W-1:0] pick_address();
		int                roll;
		logic [ADDR_W-1:0] word;
		roll = $urandom % 100;
		// Few words per window so reads often land on written bytes
		word = ADDR_W'($urandom % 32) << 2;
		if (roll < 45) begin
			return S0_BASE_DEF + word;
		end
		if (roll < 90) begin
			return S1_BASE_DEF + word;
		end
		// Gap from 0x400 to 0xFFC
		return ADDR_W'(32'h400) + (ADDR_W'($urandom % 768) << 2);
	endfunction

	// One master: request, hold until ack or err, then idle
	task automatic run_master(input int id);
		int gap;
		for (int n = 0; n < N_TRANS; n++) begin
			@(posedge clk);
			cyc[id]   <= 1'b1;
			stb[id]   <= 1'b1;
			we[id]    <= 1'($urandom);
			adr[id]   <= pick_address();
			sel[id]   <= SEL_W'($urandom);
			dat_w[id] <= $urandom;
			do begin
				@(posedge clk);
			end while (!(ack[id] || err[id]));
			// Mandatory idle cycle starts here
			cyc[id] <= 1'b0;
			stb[id] <= 1'b0;
			gap = $urandom % 4;
			repeat (gap) @(posedge clk);
		end
	endtask

	initial begin
		clk   = 1'b0;
		rstn  = 1'b0;
		cyc   = '0;
		stb   = '0;
		we    = '0;
		adr   = '0;
		sel   = '0;
		dat_w = '0;
		void'($urandom(SEED));
		repeat (2) @(posedge clk);
		rstn <= 1'b1;
		// Forked masters inherit the seeded generator
		fork
			run_master(0);
			run_master(1);
		join
		// Let the last responses reach the monitor
		repeat (4) @(posedge clk);
		total_errs = err_cnt + wb_soc_top_i.crossbar_i.chk_i.assert_fails;
		$display("transfers checked: %0d, errors: %0d", chk_cnt, total_errs);
		if (total_errs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Cycle limit against a hung handshake
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("sim failed");
			$finish;
		end
	end

	wb_soc_top wb_soc_top_i (
		.clk        (clk),
		.rstn       (rstn),
		.m0_cyc_i   (cyc[0]),
		.m0_stb_i   (stb[0]),
		.m0_we_i    (we[0]),
		.m0_adr_i   (adr[0]),
		.m0_sel_i   (sel[0]),
		.m0_dat_w_i (dat_w[0]),
		.m0_dat_r_o (dat_r[0]),
		.m0_ack_o   (ack[0]),
		.m0_err_o   (err[0]),
		.m1_cyc_i   (cyc[1]),
		.m1_stb_i   (stb[1]),
		.m1_we_i    (we[1]),
		.m1_adr_i   (adr[1]),
		.m1_sel_i   (sel[1]),
		.m1_dat_w_i (dat_w[1]),
		.m1_dat_r_o (dat_r[1]),
		.m1_ack_o   (ack[1]),
		.m1_err_o   (err[1])
	);

	tb_monitor monitor_i (
		.clk       (clk),
		.rstn      (rstn),
		.cyc_i     (cyc),
		.stb_i     (stb),
		.we_i      (we),
		.adr_i     (adr),
		.sel_i     (sel),
		.dat_w_i   (dat_w),
		.dat_r_i   (dat_r),
		.ack_i     (ack),
		.err_i     (err),
		.err_cnt_o (err_cnt),
		.chk_cnt_o (chk_cnt)
	);

endmodule

// File: testbench/wb_xbar_chk.sv
/*
 * Crossbar assertions: one response kind per master, responses only
 * while stb is high, no target stb without its arbiter grant
 */
`timescale 1ns/1ps

module wb_xbar_chk (
	input logic clk,
	input logic rstn,
	input logic m0_stb_i,
	input logic m0_ack_i,
	input logic m0_err_i,
	input logic m1_stb_i,
	input logic m1_ack_i,
	input logic m1_err_i,
	input logic s0_stb_i,
	input logic s1_stb_i,
	input logic e_stb_i,
	input logic s0_gnt_i,
	input logic s1_gnt_i,
	input logic e_gnt_i
);

	int assert_fails = 0;

	// Never ack and err together
	a_m0_one_kind: assert property (@(posedge clk) disable iff (!rstn)
		!(m0_ack_i && m0_err_i))
		else begin
			assert_fails++;
			$error("master 0 sees ack and err together");
		end
	a_m1_one_kind: assert property (@(posedge clk) disable iff (!rstn)
		!(m1_ack_i && m1_err_i))
		else begin
			assert_fails++;
			$error("master 1 sees ack and err together");
		end

	// Responses only to a master holding stb
	a_m0_rsp_stb: assert property (@(posedge clk) disable iff (!rstn)
		(m0_ack_i || m0_err_i) |-> m0_stb_i)
		else begin
			assert_fails++;
			$error("master 0 response without stb");
		end
	a_m1_rsp_stb: assert property (@(posedge clk) disable iff (!rstn)
		(m1_ack_i || m1_err_i) |-> m1_stb_i)
		else begin
			assert_fails++;
			$error("master 1 response without stb");
		end

	// Target strobes need a grant, error responder included
	a_tgt_gnt: assert property (@(posedge clk) disable iff (!rstn)
		(!s0_stb_i || s0_gnt_i) && (!s1_stb_i || s1_gnt_i) && (!e_stb_i || e_gnt_i))
		else begin
			assert_fails++;
			$error("target stb high while its arbiter has no grant");
		end

endmodule

bind wb_xbar_2x2 wb_xbar_chk chk_i (
	.clk      (clk),
	.rstn     (rstn),
	.m0_stb_i (m0_stb_i),
	.m0_ack_i (m0_ack_o),
	.m0_err_i (m0_err_o),
	.m1_stb_i (m1_stb_i),
	.m1_ack_i (m1_ack_o),
	.m1_err_i (m1_err_o),
	.s0_stb_i (s0_stb_o),
	.s1_stb_i (s1_stb_o),
	.e_stb_i  (t_stb[2]),
	.s0_gnt_i (gnt[0]),
	.s1_gnt_i (gnt[1]),
	.e_gnt_i  (gnt[2])
);

// File: verilog/wb_bus_pkg.sv
/*
 * Wishbone bus widths for the crossbar, the SRAM targets and the testbench
 * Byte-select width and master count
 */
package wb_bus_pkg;

	// Byte address, full 32-bit space
	localparam int ADDR_W = 32;

	// Word-wide data path
	localparam int DATA_W = 32;

	// One select bit per data byte
	localparam int SEL_W = DATA_W / 8;

	// Masters sharing the bus
	// Also sizes every arbiter request vector
	localparam int N_MASTERS = 2;

endpackage

// File: verilog/wb_map_pkg.sv
/*
 * Default address map of the two SRAM windows
 * Target index width and the error and idle index codes
 */
package wb_map_pkg;

	// Target 0 window, 1 KiB
	localparam logic [wb_bus_pkg::ADDR_W-1:0] S0_BASE_DEF  = 32'h0000_0000;
	localparam logic [wb_bus_pkg::ADDR_W-1:0] S0_LIMIT_DEF = 32'h0000_03FF;

	// Target 1 window, 1 KiB at 4 KiB
	localparam logic [wb_bus_pkg::ADDR_W-1:0] S1_BASE_DEF  = 32'h0000_1000;
	localparam logic [wb_bus_pkg::ADDR_W-1:0] S1_LIMIT_DEF = 32'h0000_13FF;

	// Index held per master: 0 and 1 are SRAMs
	localparam int TGT_W = 2;
	// Decode-error responder
	localparam logic [TGT_W-1:0] TGT_ERR  = 2'd2;
	// Master idle, nothing selected
	localparam logic [TGT_W-1:0] TGT_NONE = 2'd3;

endpackage

// File: verilog/wb_rr_arbiter.sv
/*
 * Round-robin arbiter for one shared target
 * Grant held until the granted request drops, then one idle cycle
 */
`timescale 1ns/1ps

module wb_rr_arbiter #(
	parameter int N_REQ = 2
) (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic [N_REQ-1:0]         req_i,
	output logic                     gnt_o,
	output logic [$clog2(N_REQ)-1:0] gnt_id_o
);

	localparam int ID_W = $clog2(N_REQ);

	// Candidate for the next grant
	logic            pick_vld;
	logic [ID_W-1:0] pick_id;

	// gnt_id_o keeps the last winner while idle
	// and serves as the rotation pointer
	always_comb begin
		pick_vld = |req_i;
		pick_id  = '0;
		// Lowest requester as fallback
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (req_i[i]) begin
				pick_id = ID_W'(i);
			end
		end
		// First requester above the last grant wins if there is one
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (req_i[i] && (i > int'(gnt_id_o))) begin
				pick_id = ID_W'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o    <= 1'b0;
			// Pointer at the top, so the first grant goes to the lowest
			gnt_id_o <= ID_W'(N_REQ - 1);
		end else if (!gnt_o) begin
			// Idle, register a grant one edge after a request
			if (pick_vld) begin
				gnt_o    <= 1'b1;
				gnt_id_o <= pick_id;
			end
		end else if (!req_i[gnt_id_o]) begin
			// Owner gone, release and idle for one cycle
			gnt_o <= 1'b0;
		end
	end

endmodule

// File: verilog/wb_soc_top.sv
/*
 * Shared-bus top: crossbar plus two SRAM targets
 * Sets the address map, SRAM depth and wait states
 */
`timescale 1ns/1ps

module wb_soc_top (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          m0_cyc_i,
	input  logic                          m0_stb_i,
	input  logic                          m0_we_i,
	input  logic [wb_bus_pkg::ADDR_W-1:0] m0_adr_i,
	input  logic [wb_bus_pkg::SEL_W-1:0]  m0_sel_i,
	input  logic [wb_bus_pkg::DATA_W-1:0] m0_dat_w_i,
	output logic [wb_bus_pkg::DATA_W-1:0] m0_dat_r_o,
	output logic                          m0_ack_o,
	output logic                          m0_err_o,
	input  logic                          m1_cyc_i,
	input  logic                          m1_stb_i,
	input  logic                          m1_we_i,
	input  logic [wb_bus_pkg::ADDR_W-1:0] m1_adr_i,
	input  logic [wb_bus_pkg::SEL_W-1:0]  m1_sel_i,
	input  logic [wb_bus_pkg::DATA_W-1:0] m1_dat_w_i,
	output logic [wb_bus_pkg::DATA_W-1:0] m1_dat_r_o,
	output logic                          m1_ack_o,
	output logic                          m1_err_o
);

	import wb_bus_pkg::*;
	import wb_map_pkg::*;

	// 1 KiB per window
	localparam int MEM_WORDS = 256;
	localparam int MEM_AW    = $clog2(MEM_WORDS);
	localparam int S0_WAIT   = 1;
	localparam int S1_WAIT   = 2;

	// Crossbar to SRAM wiring
	logic              s0_stb, s0_we, s0_ack;
	logic              s1_stb, s1_we, s1_ack;
	logic [ADDR_W-1:0] s0_adr, s1_adr;
	logic [SEL_W-1:0]  s0_sel, s1_sel;
	logic [DATA_W-1:0] s0_dat_w, s0_dat_r;
	logic [DATA_W-1:0] s1_dat_w, s1_dat_r;

	wb_xbar_2x2 #(
		.S0_BASE  (S0_BASE_DEF),
		.S0_LIMIT (S0_LIMIT_DEF),
		.S1_BASE  (S1_BASE_DEF),
		.S1_LIMIT (S1_LIMIT_DEF)
	) crossbar_i (
		.clk        (clk),
		.rstn       (rstn),
		.m0_cyc_i   (m0_cyc_i),
		.m0_stb_i   (m0_stb_i),
		.m0_we_i    (m0_we_i),
		.m0_adr_i   (m0_adr_i),
		.m0_sel_i   (m0_sel_i),
		.m0_dat_w_i (m0_dat_w_i),
		.m0_dat_r_o (m0_dat_r_o),
		.m0_ack_o   (m0_ack_o),
		.m0_err_o   (m0_err_o),
		.m1_cyc_i   (m1_cyc_i),
		.m1_stb_i   (m1_stb_i),
		.m1_we_i    (m1_we_i),
		.m1_adr_i   (m1_adr_i),
		.m1_sel_i   (m1_sel_i),
		.m1_dat_w_i (m1_dat_w_i),
		.m1_dat_r_o (m1_dat_r_o),
		.m1_ack_o   (m1_ack_o),
		.m1_err_o   (m1_err_o),
		.s0_stb_o   (s0_stb),
		.s0_we_o    (s0_we),
		.s0_adr_o   (s0_adr),
		.s0_sel_o   (s0_sel),
		.s0_dat_w_o (s0_dat_w),
		.s0_dat_r_i (s0_dat_r),
		.s0_ack_i   (s0_ack),
		.s1_stb_o   (s1_stb),
		.s1_we_o    (s1_we),
		.s1_adr_o   (s1_adr),
		.s1_sel_o   (s1_sel),
		.s1_dat_w_o (s1_dat_w),
		.s1_dat_r_i (s1_dat_r),
		.s1_ack_i   (s1_ack)
	);

	// Word index taken above the byte offset
	wb_sram_target #(
		.MEM_WORDS   (MEM_WORDS),
		.WAIT_STATES (S0_WAIT)
	) sram0_i (
		.clk     (clk),
		.rstn    (rstn),
		.stb_i   (s0_stb),
		.we_i    (s0_we),
		.sel_i   (s0_sel),
		.adr_i   (s0_adr[MEM_AW+1:2]),
		.dat_w_i (s0_dat_w),
		.dat_r_o (s0_dat_r),
		.ack_o   (s0_ack)
	);

	// Slower target, one more wait state
	wb_sram_target #(
		.MEM_WORDS   (MEM_WORDS),
		.WAIT_STATES (S1_WAIT)
	) sram1_i (
		.clk     (clk),
		.rstn    (rstn),
		.stb_i   (s1_stb),
		.we_i    (s1_we),
		.sel_i   (s1_sel),
		.adr_i   (s1_adr[MEM_AW+1:2]),
		.dat_w_i (s1_dat_w),
		.dat_r_o (s1_dat_r),
		.ack_o   (s1_ack)
	);

endmodule

// File: verilog/wb_sram_target.sv
/*
 * Wishbone classic SRAM target, one word per address
 * Byte selects and a fixed number of wait states before ack
 */
`timescale 1ns/1ps

module wb_sram_target #(
	parameter int MEM_WORDS   = 256,
	parameter int WAIT_STATES = 0
) (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          stb_i,
	input  logic                          we_i,
	input  logic [wb_bus_pkg::SEL_W-1:0]  sel_i,
	input  logic [$clog2(MEM_WORDS)-1:0]  adr_i,
	input  logic [wb_bus_pkg::DATA_W-1:0] dat_w_i,
	output logic [wb_bus_pkg::DATA_W-1:0] dat_r_o,
	output logic                          ack_o
);

	import wb_bus_pkg::*;

	// Counter needs at least one bit even with no wait states
	localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

	logic [DATA_W-1:0] mem [MEM_WORDS];
	logic [CNT_W-1:0]  wait_cnt;
	// Last wait cycle done, access on this edge
	logic              acc_go;

	// Never fire in the cycle that already carries ack
	assign acc_go = stb_i && !ack_o && (wait_cnt == CNT_W'(WAIT_STATES));

	// Wait counter and ack pulse
	always_ff @(posedge clk) begin
		if (!rstn) begin
			wait_cnt <= '0;
			ack_o    <= 1'b0;
		end else begin
			ack_o <= acc_go;
			if (!stb_i || ack_o || acc_go) begin
				wait_cnt <= '0;
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	// Array access on the ack edge
	always_ff @(posedge clk) begin
		if (acc_go) begin
			if (we_i) begin
				// Only selected bytes change
				for (int b = 0; b < SEL_W; b++) begin
					if (sel_i[b]) begin
						mem[adr_i][b*8 +: 8] <= dat_w_i[b*8 +: 8];
					end
				end
			end else begin
				dat_r_o <= mem[adr_i];
			end
		end
	end

endmodule

// File: verilog/wb_xbar_2x2.sv
/*
 * Two-master, two-target Wishbone classic crossbar
 * Per-master decode FSM, per-target round-robin arbitration,
 * request and response steering, decode-error responder
 */
`timescale 1ns/1ps

module wb_xbar_2x2 #(
	parameter logic [wb_bus_pkg::ADDR_W-1:0] S0_BASE  = wb_map_pkg::S0_BASE_DEF,
	parameter logic [wb_bus_pkg::ADDR_W-1:0] S0_LIMIT = wb_map_pkg::S0_LIMIT_DEF,
	parameter logic [wb_bus_pkg::ADDR_W-1:0] S1_BASE  = wb_map_pkg::S1_BASE_DEF,
	parameter logic [wb_bus_pkg::ADDR_W-1:0] S1_LIMIT = wb_map_pkg::S1_LIMIT_DEF
) (
	input  logic                          clk,
	input  logic                          rstn,
	// Master 0
	input  logic                          m0_cyc_i,
	input  logic                          m0_stb_i,
	input  logic                          m0_we_i,
	input  logic [wb_bus_pkg::ADDR_W-1:0] m0_adr_i,
	input  logic [wb_bus_pkg::SEL_W-1:0]  m0_sel_i,
	input  logic [wb_bus_pkg::DATA_W-1:0] m0_dat_w_i,
	output logic [wb_bus_pkg::DATA_W-1:0] m0_dat_r_o,
	output logic                          m0_ack_o,
	output logic                          m0_err_o,
	// Master 1
	input  logic                          m1_cyc_i,
	input  logic                          m1_stb_i,
	input  logic                          m1_we_i,
	input  logic [wb_bus_pkg::ADDR_W-1:0] m1_adr_i,
	input  logic [wb_bus_pkg::SEL_W-1:0]  m1_sel_i,
	input  logic [wb_bus_pkg::DATA_W-1:0] m1_dat_w_i,
	output logic [wb_bus_pkg::DATA_W-1:0] m1_dat_r_o,
	output logic                          m1_ack_o,
	output logic                          m1_err_o,
	// Target 0
	output logic                          s0_stb_o,
	output logic                          s0_we_o,
	output logic [wb_bus_pkg::ADDR_W-1:0] s0_adr_o,
	output logic [wb_bus_pkg::SEL_W-1:0]  s0_sel_o,
	output logic [wb_bus_pkg::DATA_W-1:0] s0_dat_w_o,
	input  logic [wb_bus_pkg::DATA_W-1:0] s0_dat_r_i,
	input  logic                          s0_ack_i,
	// Target 1
	output logic                          s1_stb_o,
	output logic                          s1_we_o,
	output logic [wb_bus_pkg::ADDR_W-1:0] s1_adr_o,
	output logic [wb_bus_pkg::SEL_W-1:0]  s1_sel_o,
	output logic [wb_bus_pkg::DATA_W-1:0] s1_dat_w_o,
	input  logic [wb_bus_pkg::DATA_W-1:0] s1_dat_r_i,
	input  logic                          s1_ack_i
);

	import wb_bus_pkg::*;
	import wb_map_pkg::*;

	// Two SRAMs plus the error responder
	localparam int N_TGT = 3;
	localparam int N_MEM = 2;
	localparam int ID_W  = $clog2(N_MASTERS);

	typedef enum logic {M_IDLE, M_BUSY} mst_state_t;

	// Master ports gathered for indexing
	logic              m_cyc   [N_MASTERS];
	logic              m_stb   [N_MASTERS];
	logic              m_we    [N_MASTERS];
	logic [ADDR_W-1:0] m_adr   [N_MASTERS];
	logic [SEL_W-1:0]  m_sel   [N_MASTERS];
	logic [DATA_W-1:0] m_dat_w [N_MASTERS];
	logic [DATA_W-1:0] m_dat_r [N_MASTERS];
	logic              m_ack   [N_MASTERS];
	logic              m_err   [N_MASTERS];

	mst_state_t        m_state [N_MASTERS];
	logic [TGT_W-1:0]  sel_tgt [N_MASTERS];

	// Arbitration, one column per target
	logic [N_MASTERS-1:0] tgt_req [N_TGT];
	logic [N_MASTERS-1:0] route   [N_TGT];
	logic                 gnt     [N_TGT];
	logic [ID_W-1:0]      gnt_id  [N_TGT];

	// Steered requests and returned responses
	logic              t_stb   [N_TGT];
	logic              t_we    [N_MEM];
	logic [ADDR_W-1:0] t_adr   [N_MEM];
	logic [SEL_W-1:0]  t_sel   [N_MEM];
	logic [DATA_W-1:0] t_dat_w [N_MEM];
	logic [DATA_W-1:0] rsp_dat [N_TGT];
	logic              rsp_ack [N_TGT];
	logic              rsp_err [N_TGT];

	// Error responder pulse
	logic              err_q;

	// Unmapped addresses go to the error responder
	function automatic logic [TGT_W-1:0] decode(input logic [ADDR_W-1:0] adr);
		if (adr >= S0_BASE && adr <= S0_LIMIT) begin
			return TGT_W'(0);
		end
		if (adr >= S1_BASE && adr <= S1_LIMIT) begin
			return TGT_W'(1);
		end
		return TGT_ERR;
	endfunction

	assign m_cyc   = '{m0_cyc_i, m1_cyc_i};
	assign m_stb   = '{m0_stb_i, m1_stb_i};
	assign m_we    = '{m0_we_i, m1_we_i};
	assign m_adr   = '{m0_adr_i, m1_adr_i};
	assign m_sel   = '{m0_sel_i, m1_sel_i};
	assign m_dat_w = '{m0_dat_w_i, m1_dat_w_i};

	assign m0_dat_r_o = m_dat_r[0];
	assign m0_ack_o   = m_ack[0];
	assign m0_err_o   = m_err[0];
	assign m1_dat_r_o = m_dat_r[1];
	assign m1_ack_o   = m_ack[1];
	assign m1_err_o   = m_err[1];

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_mst
		// Latch the target on the first cyc and stb edge
		// Clear it when the response comes back
		always_ff @(posedge clk) begin
			if (!rstn) begin
				m_state[m] <= M_IDLE;
				sel_tgt[m] <= TGT_NONE;
			end else begin
				case (m_state[m])
					M_IDLE: begin
						if (m_cyc[m] && m_stb[m]) begin
							m_state[m] <= M_BUSY;
							sel_tgt[m] <= decode(m_adr[m]);
						end
					end
					default: begin
						if (m_ack[m] || m_err[m]) begin
							m_state[m] <= M_IDLE;
							sel_tgt[m] <= TGT_NONE;
						end
					end
				endcase
			end
		end

		// Response only to the selected and granted master
		always_comb begin
			m_dat_r[m] = '0;
			m_ack[m]   = 1'b0;
			m_err[m]   = 1'b0;
			for (int t = 0; t < N_TGT; t++) begin
				if (route[t][m]) begin
					m_dat_r[m] = rsp_dat[t];
					m_ack[m]   = rsp_ack[t];
					m_err[m]   = rsp_err[t];
				end
			end
		end
	end

	for (genvar t = 0; t < N_TGT; t++) begin : g_tgt
		for (genvar m = 0; m < N_MASTERS; m++) begin : g_req
			assign tgt_req[t][m] = (sel_tgt[m] == TGT_W'(t));
			assign route[t][m]   = tgt_req[t][m] && gnt[t] && (gnt_id[t] == ID_W'(m));
		end

		wb_rr_arbiter #(
			.N_REQ (N_MASTERS)
		) arb_i (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (tgt_req[t]),
			.gnt_o    (gnt[t]),
			.gnt_id_o (gnt_id[t])
		);

		// cyc folded into stb, so targets need no cyc
		assign t_stb[t] = route[t][gnt_id[t]] && m_cyc[gnt_id[t]] && m_stb[gnt_id[t]];
	end

	// SRAM request payload, zeros when nobody holds the grant
	for (genvar t = 0; t < N_MEM; t++) begin : g_mem
		assign t_we[t]    = gnt[t] ? m_we[gnt_id[t]] : 1'b0;
		assign t_adr[t]   = gnt[t] ? m_adr[gnt_id[t]] : '0;
		assign t_sel[t]   = gnt[t] ? m_sel[gnt_id[t]] : '0;
		assign t_dat_w[t] = gnt[t] ? m_dat_w[gnt_id[t]] : '0;
	end

	assign s0_stb_o   = t_stb[0];
	assign s0_we_o    = t_we[0];
	assign s0_adr_o   = t_adr[0];
	assign s0_sel_o   = t_sel[0];
	assign s0_dat_w_o = t_dat_w[0];
	assign s1_stb_o   = t_stb[1];
	assign s1_we_o    = t_we[1];
	assign s1_adr_o   = t_adr[1];
	assign s1_sel_o   = t_sel[1];
	assign s1_dat_w_o = t_dat_w[1];

	// SRAMs never answer with err
	assign rsp_dat = '{s0_dat_r_i, s1_dat_r_i, '0};
	assign rsp_ack = '{s0_ack_i, s1_ack_i, 1'b0};
	assign rsp_err = '{1'b0, 1'b0, err_q};

	// Decode-error responder: one err a cycle after a granted stb
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= t_stb[TGT_ERR] && !err_q;
		end
	end

endmodule
